// ==== verif/bpu_trace.txt ====
# stall squash squash_pc update upd_start c_en c_off c_tgt t_en t_kind t_off t_tgt upd_taken
# then expected: pred_valid start target taken redirect last_valid (hex, kind 0=COND 3=RET)
0 0 00000000 0 00000000 0 0 00000000 0 0 0 00000000 0 1 00001000 00001020 0 0 0
0 0 00000000 0 00000000 0 0 00000000 0 0 0 00000000 0 1 00001020 00001040 0 0 1
0 0 00000000 0 00000000 0 0 00000000 0 0 0 00000000 0 1 00001040 00001060 0 0 1
0 0 00000000 1 00002000 0 0 00000000 1 1 2 00003000 2 1 00001060 00001080 0 0 1
0 1 00002004 0 00000000 0 0 00000000 0 0 0 00000000 0 0 00001080 000010a0 0 0 0
0 0 00000000 0 00000000 0 0 00000000 0 0 0 00000000 0 1 00002004 00002024 0 0 0
0 0 00000000 0 00000000 0 0 00000000 0 0 0 00000000 0 1 00002004 00003000 1 1 1
0 0 00000000 0 00000000 0 0 00000000 0 0 0 00000000 0 1 00003000 00003020 0 0 0
0 0 00000000 0 00000000 0 0 00000000 0 0 0 00000000 0 1 00003020 00003040 0 0 1
0 0 00000000 1 00004040 1 1 00005000 0 0 0 00000000 1 1 00003040 00003060 0 0 1
0 0 00000000 1 00004040 1 1 00005000 0 0 0 00000000 1 1 00003060 00003080 0 0 1
0 1 00004040 0 00000000 0 0 00000000 0 0 0 00000000 0 0 00003080 000030a0 0 0 0
0 0 00000000 1 00004040 1 1 00005000 0 0 0 00000000 0 1 00004040 00005000 1 0 0
0 0 00000000 0 00000000 0 0 00000000 0 0 0 00000000 0 1 00005000 00005020 0 0 1
0 1 00004040 0 00000000 0 0 00000000 0 0 0 00000000 0 0 00005020 00005040 0 0 0
0 0 00000000 0 00000000 0 0 00000000 0 0 0 00000000 0 1 00004040 00004060 0 0 0
0 0 00000000 1 00004040 1 1 00005000 0 0 0 00000000 0 1 00004040 00005000 1 1 1
0 1 00004040 0 00000000 0 0 00000000 0 0 0 00000000 0 0 00005000 00005020 0 0 0
0 0 00000000 1 00006080 0 0 00000000 1 2 7 000070c0 2 1 00004040 00004060 0 0 0
0 0 00000000 1 000070c0 0 0 00000000 1 3 0 00009000 2 1 00004060 00004080 0 0 1
0 1 00006080 0 00000000 0 0 00000000 0 0 0 00000000 0 0 00004080 000040a0 0 0 0
0 0 00000000 0 00000000 0 0 00000000 0 0 0 00000000 0 1 00006080 000070c0 1 0 0
0 0 00000000 0 00000000 0 0 00000000 0 0 0 00000000 0 1 000070c0 00009000 1 0 1
0 0 00000000 0 00000000 0 0 00000000 0 0 0 00000000 0 1 000070c0 000060a0 1 1 1
0 0 00000000 0 00000000 0 0 00000000 0 0 0 00000000 0 1 000060a0 000060c0 0 0 0
1 0 00000000 0 00000000 0 0 00000000 0 0 0 00000000 0 1 000060c0 000060e0 0 0 0
1 0 00000000 0 00000000 0 0 00000000 0 0 0 00000000 0 1 000060c0 000060e0 0 0 0
1 0 00000000 0 00000000 0 0 00000000 0 0 0 00000000 0 1 000060c0 000060e0 0 0 0
0 0 00000000 0 00000000 0 0 00000000 0 0 0 00000000 0 1 000060c0 000060e0 0 0 1
0 0 00000000 0 00000000 0 0 00000000 0 0 0 00000000 0 1 000060e0 00006100 0 0 1

// ==== list.f ====
logic/bpu_cfg_pkg.sv
logic/bpu_types_pkg.sv
logic/bpu_ifc.sv
logic/micro_btb.sv
logic/main_btb.sv
logic/bimodal_dir.sv
logic/return_stack.sv
logic/s2_resolve.sv
logic/branch_predictor.sv
verif/bpu_checker.sv
verif/bpu_tb.sv

// ==== verif/bpu_tb.sv ====
`timescale 1ns/1ns

module bpu_tb;
    import bpu_cfg_pkg::*;
    import bpu_types_pkg::*;

    localparam int FIELDS = 19;
    localparam int LINE_W = 8 * 160;

    logic               clk;
    logic               rst;
    logic               stall;
    logic               squash;
    logic [VADDR_W-1:0] squash_pc;
    logic               update;
    upd_t               upd;
    pred_t              pred;
    logic               pred_valid;
    logic               redirect;
    logic               last_valid;
    logic [VADDR_W-1:0] last_start;

    logic               chk_en;
    logic               exp_valid;
    logic [VADDR_W-1:0] exp_start;
    logic [VADDR_W-1:0] exp_target;
    logic               exp_taken;
    logic               exp_redirect;
    logic               exp_last_valid;
    logic [VADDR_W-1:0] exp_last_start;
    logic [VADDR_W-1:0] issued_start;
    int                 err_cnt;
    int                 chk_cnt;
    int                 trace_lines;
    int                 bad_lines;

    logic [LINE_W-1:0]  lines [$];
    logic [31:0]        col [FIELDS];

    branch_predictor u_dut (
        .clk          (clk),
        .rst          (rst),
        .stall_i      (stall),
        .squash_i     (squash),
        .squash_pc_i  (squash_pc),
        .update_i     (update),
        .upd_i        (upd),
        .pred_o       (pred),
        .pred_valid_o (pred_valid),
        .redirect_o   (redirect),
        .last_valid_o (last_valid),
        .last_start_o (last_start)
    );

    bpu_checker u_checker (
        .clk              (clk),
        .chk_en_i         (chk_en),
        .pred_i           (pred),
        .pred_valid_i     (pred_valid),
        .redirect_i       (redirect),
        .last_valid_i     (last_valid),
        .last_start_i     (last_start),
        .exp_valid_i      (exp_valid),
        .exp_start_i      (exp_start),
        .exp_target_i     (exp_target),
        .exp_taken_i      (exp_taken),
        .exp_redirect_i   (exp_redirect),
        .exp_last_valid_i (exp_last_valid),
        .exp_last_start_i (exp_last_start),
        .err_cnt_o        (err_cnt),
        .chk_cnt_o        (chk_cnt)
    );

    always #10 clk = ~clk;

    function automatic int parse_line(input logic [LINE_W-1:0] text);
        return $sscanf(text,
            "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
            col[0], col[1], col[2], col[3], col[4], col[5], col[6],
            col[7], col[8], col[9], col[10], col[11], col[12], col[13],
            col[14], col[15], col[16], col[17], col[18]);
    endfunction

    task automatic load_trace(input int fd);
        logic [LINE_W-1:0] text;
        int n;
        while (!$feof(fd)) begin
            text = '0;
            if ($fgets(text, fd) != 0) begin
                n = parse_line(text);
                if (n == FIELDS) begin
                    lines.push_back(text);
                end else if (n > 0) begin
                    bad_lines = bad_lines + 1;
                    $display("trace line has %0d fields instead of %0d", n, FIELDS);
                end
            end
        end
        trace_lines = lines.size();
    endtask

    task automatic apply_line(input logic [LINE_W-1:0] text);
        void'(parse_line(text));
        stall = col[0][0];
        squash = col[1][0];
        squash_pc = col[2];
        update = col[3][0];
        upd = '0;
        upd.start = col[4];
        upd.entry.valid = 1'b1;
        // tag sits above the set index, which sits above the byte offset in the block
        upd.entry.tag = col[4][BLK_OFFS_W + BTB_IDX_W +: BTB_TAG_W];
        upd.entry.cond_slot.en = col[5][0];
        upd.entry.cond_slot.kind = COND;
        upd.entry.cond_slot.offset = col[6][OFFS_W-1:0];
        upd.entry.cond_slot.target = col[7];
        upd.entry.tail_slot.en = col[8][0];
        upd.entry.tail_slot.kind = br_kind_t'(col[9][1:0]);
        upd.entry.tail_slot.offset = col[10][OFFS_W-1:0];
        upd.entry.tail_slot.target = col[11];
        upd.taken = col[12][NUM_SLOTS-1:0];
        exp_valid = col[13][0];
        exp_start = col[14];
        exp_target = col[15];
        exp_taken = col[16][0];
        exp_redirect = col[17][0];
        exp_last_valid = col[18][0];
    endtask

    initial begin
        int fd;
        clk = 1'b0;
        rst = 1'b1;
        stall = 1'b0;
        squash = 1'b0;
        squash_pc = '0;
        update = 1'b0;
        upd = '0;
        chk_en = 1'b0;
        exp_valid = 1'b0;
        exp_start = '0;
        exp_target = '0;
        exp_taken = 1'b0;
        exp_redirect = 1'b0;
        exp_last_valid = 1'b0;
        exp_last_start = '0;
        issued_start = '0;
        trace_lines = 0;
        bad_lines = 0;
        fd = $fopen("verif/bpu_trace.txt", "r");
        if (fd == 0) begin
            $display("could not open the trace file verif/bpu_trace.txt");
            $display("TESTS FAILED");
            $finish;
        end else begin
            load_trace(fd);
            $fclose(fd);
            repeat (16) @(posedge clk);
            @(negedge clk);
            rst = 1'b0;
            foreach (lines[i]) begin
                apply_line(lines[i]);
                // stage 2 holds the block issued in the last cycle without stall
                exp_last_start = issued_start;
                if (!stall) begin
                    issued_start = exp_start;
                end
                chk_en = 1'b1;
                @(negedge clk);
            end
            chk_en = 1'b0;
            $display("checks %0d, mismatches %0d, bad trace lines %0d, trace lines %0d",
                     chk_cnt, err_cnt, bad_lines, trace_lines);
            if (err_cnt == 0 && bad_lines == 0 && trace_lines > 0) begin
                $display("TESTS PASSED");
            end else begin
                $display("TESTS FAILED");
            end
            $finish;
        end
    end

    // bound follows the trace length, with room for reset
    initial begin
        wait (trace_lines > 0);
        #((trace_lines + 40) * 20);
        $display("watchdog expired before the trace finished");
        $display("TESTS FAILED");
        $finish;
    end

endmodule

// ==== verif/bpu_checker.sv ====
`timescale 1ns/1ns

module bpu_checker (
    input  logic                            clk,
    input  logic                            chk_en_i,
    input  bpu_types_pkg::pred_t            pred_i,
    input  logic                            pred_valid_i,
    input  logic                            redirect_i,
    input  logic                            last_valid_i,
    input  logic [bpu_cfg_pkg::VADDR_W-1:0] last_start_i,
    input  logic                            exp_valid_i,
    input  logic [bpu_cfg_pkg::VADDR_W-1:0] exp_start_i,
    input  logic [bpu_cfg_pkg::VADDR_W-1:0] exp_target_i,
    input  logic                            exp_taken_i,
    input  logic                            exp_redirect_i,
    input  logic                            exp_last_valid_i,
    input  logic [bpu_cfg_pkg::VADDR_W-1:0] exp_last_start_i,
    output int                              err_cnt_o,
    output int                              chk_cnt_o
);
    import bpu_cfg_pkg::*;
    import bpu_types_pkg::*;

    initial begin
        err_cnt_o = 0;
        chk_cnt_o = 0;
    end

    task automatic compare(input string name, input logic [VADDR_W-1:0] got,
                           input logic [VADDR_W-1:0] want);
        chk_cnt_o = chk_cnt_o + 1;
        if (got !== want) begin
            err_cnt_o = err_cnt_o + 1;
            $display("MISMATCH t=%0t %s got %h expected %h", $time, name, got, want);
        end
    endtask

    // outputs are combinational from state, so sample before the edge updates it
    always @(posedge clk) begin
        if (chk_en_i) begin
            compare("pred_valid_o", pred_valid_i, exp_valid_i);
            compare("pred_o.start", pred_i.start, exp_start_i);
            compare("pred_o.target", pred_i.target, exp_target_i);
            compare("pred_o.taken", pred_i.taken, exp_taken_i);
            compare("redirect_o", redirect_i, exp_redirect_i);
            compare("last_valid_o", last_valid_i, exp_last_valid_i);
            if (exp_last_valid_i) begin
                compare("last_start_o", last_start_i, exp_last_start_i);
            end
        end
    end

endmodule

// ==== logic/branch_predictor.sv ====
`timescale 1ns/1ns

module branch_predictor (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            stall_i,
    input  logic                            squash_i,
    input  logic [bpu_cfg_pkg::VADDR_W-1:0] squash_pc_i,
    input  logic                            update_i,
    input  bpu_types_pkg::upd_t             upd_i,
    output bpu_types_pkg::pred_t            pred_o,
    output logic                            pred_valid_o,
    output logic                            redirect_o,
    output logic                            last_valid_o,
    output logic [bpu_cfg_pkg::VADDR_W-1:0] last_start_o
);
    import bpu_cfg_pkg::*;
    import bpu_types_pkg::*;

    logic [VADDR_W-1:0]   pc;
    pred_t                s1_pred;
    pred_t                s2_q;
    pred_t                s2_pred;
    logic [NUM_SLOTS-1:0] dir_taken;
    logic                 s2_redirect;

    btb_lookup_if lookup ();
    ras_if        ras ();

    assign lookup.pc = pc;
    assign lookup.rd_en = !stall_i;

    micro_btb u_ubtb (
        .clk      (clk),
        .rst      (rst),
        .pc_i     (pc),
        .update_i (update_i),
        .upd_i    (upd_i),
        .pred_o   (s1_pred)
    );

    main_btb u_btb (
        .clk      (clk),
        .rst      (rst),
        .lookup   (lookup.sink),
        .update_i (update_i),
        .upd_i    (upd_i)
    );

    bimodal_dir u_dir (
        .clk      (clk),
        .rst      (rst),
        .pc_i     (pc),
        .rd_en_i  (!stall_i),
        .update_i (update_i),
        .upd_i    (upd_i),
        .taken_o  (dir_taken)
    );

    return_stack u_ras (
        .clk (clk),
        .rst (rst),
        .ras (ras.stack)
    );

    s2_resolve u_s2 (
        .s1_i     (s2_q),
        .lookup   (lookup.src),
        .dir_i    (dir_taken),
        .ras      (ras.user),
        .stall_i  (stall_i),
        .squash_i (squash_i),
        .s2_o     (s2_pred)
    );

    assign s2_redirect = s2_pred.redirect;

    // stage 2 overrides stage 1 when it disagrees
    assign pred_o = s2_redirect ? s2_pred : s1_pred;
    assign pred_valid_o = pred_o.valid && !squash_i;
    assign redirect_o = s2_redirect && !squash_i;
    assign last_valid_o = s2_q.valid && !squash_i && !stall_i;
    assign last_start_o = s2_q.start;

    // squash, then stall, then redirect
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc <= RESET_PC;
            s2_q <= '0;
        end else if (squash_i) begin
            pc <= squash_pc_i;
            s2_q <= '0;
        end else if (!stall_i) begin
            pc <= pred_o.target;
            s2_q <= s2_redirect ? '0 : s1_pred;
        end
    end

endmodule

// ==== logic/s2_resolve.sv ====
`timescale 1ns/1ns

module s2_resolve (
    input  bpu_types_pkg::pred_t              s1_i,
    btb_lookup_if.src                         lookup,
    input  logic [bpu_cfg_pkg::NUM_SLOTS-1:0] dir_i,
    ras_if.user                               ras,
    input  logic                              stall_i,
    input  logic                              squash_i,
    output bpu_types_pkg::pred_t              s2_o
);
    import bpu_cfg_pkg::*;
    import bpu_types_pkg::*;

    btb_entry_t           e;
    slot_t                tail;
    logic [NUM_SLOTS-1:0] tk;
    logic [NUM_SLOTS-1:0] sel;
    logic [VADDR_W-1:0]   tail_tgt;
    logic [OFFS_W:0]      tail_cnt;
    logic                 active;
    logic                 redirect;
    pred_t                s2_pred;

    assign e = lookup.entry;
    assign tail = e.tail_slot;

    // conditional slots follow the counter, others always taken
    assign tk[0] = dir_i[0];
    assign tk[1] = (tail.kind == COND) ? dir_i[1] : 1'b1;
    assign sel = first_taken(e, tk);

    assign tail_tgt = (tail.kind == RET && ras.nonempty) ? ras.top_addr : tail.target;
    assign s2_pred = build_pred(s1_i.start, e, sel, tail_tgt);

    assign active = s1_i.valid && lookup.hit && !stall_i && !squash_i;
    assign redirect = s1_i.valid && lookup.hit && !stall_i && s2_pred.target != s1_i.target;

    // return address is the instruction after the call
    assign tail_cnt = {1'b0, tail.offset} + 1'b1;
    assign ras.push_addr = s1_i.start + {{(VADDR_W - OFFS_W - 3){1'b0}}, tail_cnt, 2'b00};
    assign ras.push = active && sel[1] && tail.kind == CALL;
    assign ras.pop = active && sel[1] && tail.kind == RET;

    always_comb begin
        if (redirect) begin
            s2_o = s2_pred;
            s2_o.redirect = 1'b1;
        end else begin
            s2_o = s1_i;
        end
    end

endmodule

// ==== logic/return_stack.sv ====
`timescale 1ns/1ns

module return_stack (
    input logic   clk,
    input logic   rst,
    ras_if.stack  ras
);
    import bpu_cfg_pkg::*;

    logic [VADDR_W-1:0]   mem [RAS_DEPTH];
    logic [RAS_PTR_W-1:0] ptr;
    logic [RAS_CNT_W-1:0] count;
    logic [RAS_PTR_W-1:0] top_ptr;
    logic                 do_pop;

    assign top_ptr = ptr - 1'b1;
    assign ras.top_addr = mem[top_ptr];
    assign ras.nonempty = count != '0;
    // pop on an empty stack is dropped
    assign do_pop = ras.pop && ras.nonempty;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ptr <= '0;
            count <= '0;
        end else if (ras.push) begin
            ptr <= ptr + 1'b1;
            // oldest entry is overwritten once full
            if (count != RAS_CNT_W'(RAS_DEPTH)) begin
                count <= count + 1'b1;
            end
        end else if (do_pop) begin
            ptr <= top_ptr;
            count <= count - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (ras.push) begin
            mem[ptr] <= ras.push_addr;
        end
    end

endmodule

// ==== logic/bimodal_dir.sv ====
`timescale 1ns/1ns

module bimodal_dir (
    input  logic                              clk,
    input  logic                              rst,
    input  logic [bpu_cfg_pkg::VADDR_W-1:0]   pc_i,
    input  logic                              rd_en_i,
    input  logic                              update_i,
    input  bpu_types_pkg::upd_t               upd_i,
    output logic [bpu_cfg_pkg::NUM_SLOTS-1:0] taken_o
);
    import bpu_cfg_pkg::*;
    import bpu_types_pkg::*;

    logic [NUM_SLOTS-1:0][1:0] ctr [BTB_SETS];
    logic [BTB_IDX_W-1:0]      rd_idx;
    logic [BTB_IDX_W-1:0]      wr_idx;
    logic [NUM_SLOTS-1:0]      upd_en;

    assign rd_idx = btb_idx(pc_i);
    assign wr_idx = btb_idx(upd_i.start);
    assign upd_en = {upd_i.entry.tail_slot.en, upd_i.entry.cond_slot.en};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            taken_o <= '0;
            // weakly not-taken
            for (int s = 0; s < BTB_SETS; s++) begin
                ctr[s] <= {NUM_SLOTS{2'b01}};
            end
        end else begin
            if (rd_en_i) begin
                for (int k = 0; k < NUM_SLOTS; k++) begin
                    taken_o[k] <= ctr[rd_idx][k][1];
                end
            end
            if (update_i) begin
                for (int k = 0; k < NUM_SLOTS; k++) begin
                    if (upd_en[k] && upd_i.taken[k] && ctr[wr_idx][k] != 2'b11) begin
                        ctr[wr_idx][k] <= ctr[wr_idx][k] + 2'b01;
                    end else if (upd_en[k] && !upd_i.taken[k] && ctr[wr_idx][k] != 2'b00) begin
                        ctr[wr_idx][k] <= ctr[wr_idx][k] - 2'b01;
                    end
                end
            end
        end
    end

endmodule

// ==== logic/main_btb.sv ====
`timescale 1ns/1ns

module main_btb (
    input  logic                clk,
    input  logic                rst,
    btb_lookup_if.sink          lookup,
    input  logic                update_i,
    input  bpu_types_pkg::upd_t upd_i
);
    import bpu_cfg_pkg::*;
    import bpu_types_pkg::*;

    logic       vld [BTB_SETS];
    btb_entry_t mem [BTB_SETS];

    logic [BTB_IDX_W-1:0] rd_idx;
    logic [BTB_IDX_W-1:0] wr_idx;
    btb_entry_t           entry_q;
    logic                 hit_q;

    assign rd_idx = btb_idx(lookup.pc);
    assign wr_idx = btb_idx(upd_i.start);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hit_q <= 1'b0;
            for (int s = 0; s < BTB_SETS; s++) begin
                vld[s] <= 1'b0;
            end
        end else begin
            if (lookup.rd_en) begin
                hit_q <= vld[rd_idx] && mem[rd_idx].tag == btb_tag(lookup.pc);
            end
            if (update_i) begin
                vld[wr_idx] <= upd_i.entry.valid;
            end
        end
    end

    // read sees the old contents when a write hits the same set
    always_ff @(posedge clk) begin
        if (lookup.rd_en) begin
            entry_q <= mem[rd_idx];
        end
        if (update_i) begin
            mem[wr_idx] <= upd_i.entry;
        end
    end

    assign lookup.entry = entry_q;
    assign lookup.hit = hit_q;

endmodule

// ==== logic/micro_btb.sv ====
`timescale 1ns/1ns

module micro_btb (
    input  logic                            clk,
    input  logic                            rst,
    input  logic [bpu_cfg_pkg::VADDR_W-1:0] pc_i,
    input  logic                            update_i,
    input  bpu_types_pkg::upd_t             upd_i,
    output bpu_types_pkg::pred_t            pred_o
);
    import bpu_cfg_pkg::*;
    import bpu_types_pkg::*;

    logic                 ent_vld [UBTB_ENTRIES];
    logic [VADDR_W-1:0]   ent_pc  [UBTB_ENTRIES];
    btb_entry_t           ent     [UBTB_ENTRIES];
    logic [NUM_SLOTS-1:0] ent_tk  [UBTB_ENTRIES];

    logic                  hit;
    logic [UBTB_IDX_W-1:0] hit_idx;
    logic                  upd_hit;
    logic [UBTB_IDX_W-1:0] upd_idx;
    logic [UBTB_IDX_W-1:0] victim;
    logic [UBTB_IDX_W-1:0] wr_idx;
    logic [NUM_SLOTS-1:0]  sel;

    // full pc match on lookup and on update
    always_comb begin
        hit = 1'b0;
        hit_idx = '0;
        upd_hit = 1'b0;
        upd_idx = '0;
        for (int i = 0; i < UBTB_ENTRIES; i++) begin
            if (ent_vld[i] && ent_pc[i] == pc_i) begin
                hit = 1'b1;
                hit_idx = UBTB_IDX_W'(i);
            end
            if (ent_vld[i] && ent_pc[i] == upd_i.start) begin
                upd_hit = 1'b1;
                upd_idx = UBTB_IDX_W'(i);
            end
        end
    end

    assign sel = hit ? first_taken(ent[hit_idx], ent_tk[hit_idx]) : '0;
    assign pred_o = build_pred(pc_i, ent[hit_idx], sel, ent[hit_idx].tail_slot.target);
    assign wr_idx = upd_hit ? upd_idx : victim;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            victim <= '0;
            for (int i = 0; i < UBTB_ENTRIES; i++) begin
                ent_vld[i] <= 1'b0;
            end
        end else if (update_i) begin
            ent_vld[wr_idx] <= upd_i.entry.valid;
            // round robin only advances on allocation
            if (!upd_hit) begin
                victim <= victim + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (update_i) begin
            ent_pc[wr_idx] <= upd_i.start;
            ent[wr_idx] <= upd_i.entry;
            ent_tk[wr_idx] <= upd_i.taken;
        end
    end

endmodule

// ==== logic/bpu_ifc.sv ====
`timescale 1ns/1ns

interface btb_lookup_if;
    import bpu_cfg_pkg::*;
    import bpu_types_pkg::*;

    logic [VADDR_W-1:0] pc;
    logic               rd_en;
    btb_entry_t         entry;
    logic               hit;

    modport src (output pc, output rd_en, input entry, input hit);
    modport sink (input pc, input rd_en, output entry, output hit);
endinterface

interface ras_if;
    import bpu_cfg_pkg::*;

    logic               push;
    logic               pop;
    logic [VADDR_W-1:0] push_addr;
    logic [VADDR_W-1:0] top_addr;
    logic               nonempty;

    modport user (
        output push, output pop, output push_addr,
        input top_addr, input nonempty
    );
    modport stack (
        input push, input pop, input push_addr,
        output top_addr, output nonempty
    );
endinterface

// ==== logic/bpu_types_pkg.sv ====
package bpu_types_pkg;

    import bpu_cfg_pkg::*;

    typedef enum logic [1:0] {
        COND,
        JUMP,
        CALL,
        RET
    } br_kind_t;

    typedef struct packed {
        logic              en;
        br_kind_t          kind;
        logic [OFFS_W-1:0] offset;
        logic [VADDR_W-1:0] target;
    } slot_t;

    typedef struct packed {
        logic                 valid;
        logic [BTB_TAG_W-1:0] tag;
        slot_t                cond_slot;
        slot_t                tail_slot;
    } btb_entry_t;

    typedef struct packed {
        logic                 valid;
        logic [VADDR_W-1:0]   start;
        logic [VADDR_W-1:0]   target;
        logic                 taken;
        logic [NUM_SLOTS-1:0] slot_taken;
        logic [SIZE_W-1:0]    size;
        logic                 redirect;
    } pred_t;

    typedef struct packed {
        logic [VADDR_W-1:0]   start;
        btb_entry_t           entry;
        logic [NUM_SLOTS-1:0] taken;
    } upd_t;

    function automatic logic [BTB_IDX_W-1:0] btb_idx(logic [VADDR_W-1:0] pc);
        return pc[BLK_OFFS_W +: BTB_IDX_W];
    endfunction

    function automatic logic [BTB_TAG_W-1:0] btb_tag(logic [VADDR_W-1:0] pc);
        return pc[BLK_OFFS_W + BTB_IDX_W +: BTB_TAG_W];
    endfunction

    // one-hot pick of the earliest taken slot by offset
    function automatic logic [NUM_SLOTS-1:0] first_taken(btb_entry_t e,
                                                         logic [NUM_SLOTS-1:0] tk);
        logic c_tk;
        logic t_tk;
        c_tk = e.cond_slot.en & tk[0];
        t_tk = e.tail_slot.en & tk[1];
        first_taken = '0;
        if (c_tk && (!t_tk || e.cond_slot.offset <= e.tail_slot.offset)) begin
            first_taken = 2'b01;
        end else if (t_tk) begin
            first_taken = 2'b10;
        end
    endfunction

    function automatic pred_t build_pred(logic [VADDR_W-1:0] start, btb_entry_t e,
                                         logic [NUM_SLOTS-1:0] sel,
                                         logic [VADDR_W-1:0] tail_tgt);
        pred_t p;
        p = '0;
        p.valid = 1'b1;
        p.start = start;
        p.taken = |sel;
        p.slot_taken = sel;
        if (sel[0]) begin
            p.target = e.cond_slot.target;
            p.size = SIZE_W'(e.cond_slot.offset) + 1'b1;
        end else if (sel[1]) begin
            p.target = tail_tgt;
            p.size = SIZE_W'(e.tail_slot.offset) + 1'b1;
        end else begin
            p.target = start + VADDR_W'(BLOCK_BYTES);
            p.size = SIZE_W'(BLOCK_INSTS);
        end
        return p;
    endfunction

endpackage

// ==== logic/bpu_cfg_pkg.sv ====
package bpu_cfg_pkg;

    localparam int VADDR_W      = 32;
    localparam int BLOCK_INSTS  = 8;
    localparam int OFFS_W       = 3;
    localparam int NUM_SLOTS    = 2;
    localparam int UBTB_ENTRIES = 8;
    localparam int BTB_SETS     = 64;
    localparam int BTB_TAG_W    = 10;
    localparam int RAS_DEPTH    = 8;

    localparam logic [VADDR_W-1:0] RESET_PC = 32'h0000_1000;

    // derived sizes
    localparam int BLOCK_BYTES = BLOCK_INSTS * 4;
    localparam int BLK_OFFS_W  = $clog2(BLOCK_BYTES);
    localparam int BTB_IDX_W   = $clog2(BTB_SETS);
    localparam int UBTB_IDX_W  = $clog2(UBTB_ENTRIES);
    localparam int RAS_PTR_W   = $clog2(RAS_DEPTH);
    localparam int RAS_CNT_W   = $clog2(RAS_DEPTH + 1);
    // size field counts 1..BLOCK_INSTS
    localparam int SIZE_W      = $clog2(BLOCK_INSTS) + 1;

endpackage
